//--- afe.f
logic/afe_pkg.sv
logic/sys_bus_pkg.sv
logic/afe_regs.sv
logic/adc_frontend.sv
logic/dac_backend.sv
logic/pdm_modulator.sv
logic/afe_top.sv
sim/afe_tb.sv

//--- logic/adc_frontend.sv
module adc_frontend (
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  afe_pkg::adc_raw_pair_t adc_raw_i,
  input  logic                   dig_loop_i,
  input  afe_pkg::smp_pair_t     dac_sat_i,
  output afe_pkg::smp_pair_t     adc_dat_o
);

  import afe_pkg::*;

  adc_raw_pair_t       raw_q;      // Input register, ideally in the IOB
  adc_raw_t [N_CH-1:0] raw_ch;     // Same bits, per channel
  smp_t     [N_CH-1:0] conv_ch;    // Two's complement samples
  smp_pair_t           adc_path;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      raw_q <= '0;
    else
      raw_q <= adc_raw_i;
  end

  assign raw_ch = raw_q;

  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_ch
    // Drop reserved LSBs, then undo the negative slope
    assign conv_ch[ch] = smp_t'(neg_slope(raw_ch[ch][ADC_RAW_W-1:ADC_RSV_W]));
  end

  assign adc_path = conv_ch;

  // Loopback bypasses the converter and its register
  assign adc_dat_o = dig_loop_i ? dac_sat_i : adc_path;

  loop_takes_dac: assert property (@(posedge adc_clk)
    dig_loop_i |-> adc_dat_o == dac_sat_i)
    else $error("adc_frontend: loopback output differs from DAC samples");

endmodule

//--- logic/afe_pkg.sv
package afe_pkg;

  ////////////////////////////////////////////////////////////
  // Widths of the analog path
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // Converter word as it arrives
  localparam int unsigned ADC_RSV_W = 2;   // Reserved LSBs of the converter
  localparam int unsigned SMP_W     = 14;  // Working sample width
  localparam int unsigned N_CH      = 2;   // Channels a and b
  localparam int unsigned PDM_W     = 8;   // PDM duty byte

  typedef logic signed [SMP_W-1:0] smp_t;
  typedef logic signed [SMP_W:0]   smp_sum_t;   // One guard bit for summing
  typedef logic [ADC_RAW_W-1:0]    adc_raw_t;
  typedef logic [SMP_W-1:0]        dac_code_t;  // Unsigned, negative slope

  // Channel a sits in the low half, so index 0 of a packed array view
  typedef struct packed {
    smp_t b;
    smp_t a;
  } smp_pair_t;

  typedef struct packed {
    adc_raw_t b;
    adc_raw_t a;
  } adc_raw_pair_t;

  typedef struct packed {
    dac_code_t b;
    dac_code_t a;
  } dac_code_pair_t;

  ////////////////////////////////////////////////////////////
  // Conversion constants
  ////////////////////////////////////////////////////////////

  localparam smp_t      SMP_MAX       = {1'b0, {(SMP_W-1){1'b1}}};  // +8191
  localparam smp_t      SMP_MIN       = {1'b1, {(SMP_W-1){1'b0}}};  // -8192
  localparam dac_code_t DAC_CODE_ZERO = {1'b0, {(SMP_W-1){1'b1}}};  // Zero volts at the DAC

  // Negative slope <-> two's complement, same both ways
  function automatic logic [SMP_W-1:0] neg_slope(logic [SMP_W-1:0] val);
    return {val[SMP_W-1], ~val[SMP_W-2:0]};
  endfunction

endpackage

//--- logic/afe_regs.sv
module afe_regs #(
  parameter int unsigned N_PDM = 4
)(
  input  logic                                 adc_clk,
  input  logic                                 rst_i,
  input  sys_bus_pkg::sys_req_t                sys_req_i,
  output sys_bus_pkg::sys_rsp_t                sys_rsp_o,
  output logic                                 dig_loop_o,
  output logic [N_PDM-1:0][afe_pkg::PDM_W-1:0] pdm_cfg_o
);

  import sys_bus_pkg::*;
  import afe_pkg::*;

  logic                        req;       // Any access this cycle
  logic                        hit_id;
  logic                        hit_ctrl;
  logic [N_PDM-1:0]            hit_pdm;   // One hot over the PDM bytes
  logic                        hit_any;
  sys_data_t                   rd_data;   // Read mux before the register
  logic                        dig_loop;
  logic [N_PDM-1:0][PDM_W-1:0] pdm_cfg;
  logic                        ack_q;
  logic                        err_q;
  sys_data_t                   rdata_q;

  ////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////

  assign req = sys_req_i.wen | sys_req_i.ren;

  always_comb
  begin
    hit_id   = (sys_req_i.addr == REG_ID);
    hit_ctrl = (sys_req_i.addr == REG_CTRL);
    // PDM bytes on a fixed stride
    for (int i = 0; i < N_PDM; i++)
    begin
      hit_pdm[i] = (sys_req_i.addr == sys_addr_t'(REG_PDM0 + i * REG_STRIDE));
    end
    hit_any = hit_id | hit_ctrl | (|hit_pdm);
  end

  always_comb
  begin
    rd_data = '0;  // Unmapped reads back zero
    if (hit_id)
      rd_data = AFE_ID;
    if (hit_ctrl)
      rd_data[0] = dig_loop;
    for (int i = 0; i < N_PDM; i++)
    begin
      if (hit_pdm[i])
        rd_data[PDM_W-1:0] = pdm_cfg[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers and response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      dig_loop <= 1'b0;
      pdm_cfg  <= '0;   // All PDM outputs held low
    end
    else
    begin
      ack_q <= req;                // Fixed one cycle latency
      err_q <= req & ~hit_any;
      if (sys_req_i.wen & hit_ctrl)
        dig_loop <= sys_req_i.wdata[0];
      for (int i = 0; i < N_PDM; i++)
      begin
        if (sys_req_i.wen & hit_pdm[i])
          pdm_cfg[i] <= sys_req_i.wdata[PDM_W-1:0];
      end
    end
  end

  // Read data only sampled on reads
  always_ff @(posedge adc_clk)
  begin
    if (sys_req_i.ren)
      rdata_q <= rd_data;
  end

  assign sys_rsp_o  = '{rdata: rdata_q, ack: ack_q, err: err_q};
  assign dig_loop_o = dig_loop;
  assign pdm_cfg_o  = pdm_cfg;

  // Bus handshake rules
  ack_follows_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    req |=> sys_rsp_o.ack)
    else $error("afe_regs: request without ack one cycle later");

  ack_needs_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.ack |-> $past(req))
    else $error("afe_regs: ack without a request");

  no_wen_with_ren: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_req_i.wen && sys_req_i.ren))
    else $error("afe_regs: wen and ren high together");

endmodule

//--- logic/afe_top.sv
module afe_top #(
  parameter int unsigned N_PDM = 4   // Number of PDM outputs
)(
  input  logic                    adc_clk,
  input  logic                    rst_i,
  // Converter side
  input  afe_pkg::adc_raw_pair_t  adc_raw_i,   // Raw ADC words
  output afe_pkg::dac_code_pair_t dac_dat_o,   // Offset code to the DAC
  output logic [N_PDM-1:0]        pdm_o,       // Density modulated outputs
  // Streams from and to the signal processing
  input  afe_pkg::smp_pair_t      gen_dat_i,   // Generator samples
  input  afe_pkg::smp_pair_t      fb_dat_i,    // Feedback samples
  output afe_pkg::smp_pair_t      adc_dat_o,   // Captured or looped samples
  // Register bus
  input  sys_bus_pkg::sys_req_t   sys_req_i,
  output sys_bus_pkg::sys_rsp_t   sys_rsp_o
);

  import afe_pkg::*;

  logic                        dig_loop;  // Loopback enable
  logic [N_PDM-1:0][PDM_W-1:0] pdm_cfg;   // Duty bytes
  smp_pair_t                   dac_sat;   // Saturated sum before the register

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  afe_regs #(
    .N_PDM (N_PDM)
  ) afe_regs_inst (
    .adc_clk    (adc_clk  ),
    .rst_i      (rst_i    ),
    .sys_req_i  (sys_req_i),
    .sys_rsp_o  (sys_rsp_o),
    .dig_loop_o (dig_loop ),
    .pdm_cfg_o  (pdm_cfg  )
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk    (adc_clk  ),
    .rst_i      (rst_i    ),
    .adc_raw_i  (adc_raw_i),
    .dig_loop_i (dig_loop ),
    .dac_sat_i  (dac_sat  ),  // Loopback source
    .adc_dat_o  (adc_dat_o)
  );

  dac_backend dac_backend_inst (
    .adc_clk   (adc_clk  ),
    .rst_i     (rst_i    ),
    .gen_dat_i (gen_dat_i),
    .fb_dat_i  (fb_dat_i ),
    .dac_sat_o (dac_sat  ),
    .dac_dat_o (dac_dat_o)
  );

  pdm_modulator #(
    .N_PDM (N_PDM)
  ) pdm_modulator_inst (
    .adc_clk (adc_clk),
    .rst_i   (rst_i  ),
    .cfg_i   (pdm_cfg),
    .pdm_o   (pdm_o  )
  );

endmodule

//--- logic/dac_backend.sv
module dac_backend (
  input  logic                    adc_clk,
  input  logic                    rst_i,
  input  afe_pkg::smp_pair_t      gen_dat_i,
  input  afe_pkg::smp_pair_t      fb_dat_i,
  output afe_pkg::smp_pair_t      dac_sat_o,
  output afe_pkg::dac_code_pair_t dac_dat_o
);

  import afe_pkg::*;

  smp_t      [N_CH-1:0] gen_ch;  // Generator stream
  smp_t      [N_CH-1:0] fb_ch;   // Feedback stream
  smp_sum_t  [N_CH-1:0] sum_ch;  // Full precision sum
  logic      [N_CH-1:0] ovf_ch;
  smp_t      [N_CH-1:0] sat_ch;
  dac_code_t [N_CH-1:0] code_q;  // Output register

  assign gen_ch = gen_dat_i;
  assign fb_ch  = fb_dat_i;

  ////////////////////////////////////////////////////////////
  // Summing and saturation
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_ch
    assign sum_ch[ch] = $signed(gen_ch[ch]) + $signed(fb_ch[ch]);  // Sign extended to 15 bits

    // Top two bits disagree on overflow
    assign ovf_ch[ch] = sum_ch[ch][SMP_W] ^ sum_ch[ch][SMP_W-1];

    // Clamp toward the sign of the true sum
    assign sat_ch[ch] = ovf_ch[ch] ? (sum_ch[ch][SMP_W] ? SMP_MIN : SMP_MAX)
                                   : sum_ch[ch][SMP_W-1:0];

    // Registered code may only differ from the plain sum after an overflow
    clamp_needs_ovf: assert property (@(posedge adc_clk) disable iff (rst_i)
      !$past(rst_i) && (code_q[ch] != neg_slope($past(sum_ch[ch][SMP_W-1:0])))
      |-> $past(ovf_ch[ch]))
      else $error("dac_backend: channel %0d clamped without overflow", ch);
  end

  ////////////////////////////////////////////////////////////
  // Output register, back to offset code
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      code_q <= {N_CH{DAC_CODE_ZERO}};  // Mid scale
    else
    begin
      for (int ch = 0; ch < N_CH; ch++)
      begin
        code_q[ch] <= neg_slope(sat_ch[ch]);
      end
    end
  end

  assign dac_sat_o = sat_ch;  // Also feeds the loopback path
  assign dac_dat_o = code_q;

endmodule

//--- logic/pdm_modulator.sv
module pdm_modulator #(
  parameter int unsigned N_PDM = 4
)(
  input  logic                                 adc_clk,
  input  logic                                 rst_i,
  input  logic [N_PDM-1:0][afe_pkg::PDM_W-1:0] cfg_i,
  output logic [N_PDM-1:0]                     pdm_o
);

  import afe_pkg::*;

  // First order sigma delta, one accumulator per output
  logic [N_PDM-1:0][PDM_W-1:0] acc;
  logic [N_PDM-1:0][PDM_W:0]   acc_nxt;  // Carry in the top bit

  ////////////////////////////////////////////////////////////
  // Accumulate and emit the carry
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < N_PDM; i++)
    begin
      acc_nxt[i] = {1'b0, acc[i]} + {1'b0, cfg_i[i]};
      pdm_o[i]   = acc_nxt[i][PDM_W];  // cfg ones per 256 cycles
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      acc <= '0;
    else
    begin
      for (int i = 0; i < N_PDM; i++)
      begin
        acc[i] <= acc_nxt[i][PDM_W-1:0];  // Wraps modulo 256
      end
    end
  end

endmodule

//--- logic/sys_bus_pkg.sv
package sys_bus_pkg;

  localparam int unsigned SYS_AW = 20;  // Byte address
  localparam int unsigned SYS_DW = 32;

  typedef logic [SYS_AW-1:0] sys_addr_t;
  typedef logic [SYS_DW-1:0] sys_data_t;

  // Master to slave, one cycle strobes
  typedef struct packed {
    sys_addr_t addr;
    sys_data_t wdata;
    logic      wen;
    logic      ren;
  } sys_req_t;

  // Slave to master, one cycle after the strobe
  typedef struct packed {
    sys_data_t rdata;
    logic      ack;
    logic      err;   // Unmapped address
  } sys_rsp_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam sys_addr_t REG_ID     = 20'h00000;  // Read only
  localparam sys_addr_t REG_CTRL   = 20'h00004;  // Bit 0 digital loopback
  localparam sys_addr_t REG_PDM0   = 20'h00010;  // First PDM duty byte
  localparam sys_addr_t REG_STRIDE = 20'h00004;  // Spacing of the PDM registers

  localparam sys_data_t AFE_ID = 32'h0AFE_0200;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AFE testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f afe.f --top-module afe_tb -o afe_tb \
  && ./obj_dir/afe_tb | tee sim.log \
  || echo "Build or run did not complete"

grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/afe_tb.sv
module afe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import afe_pkg::*;
  import sys_bus_pkg::*;

  localparam int N_PDM    = 4;
  localparam int SEED     = 21720;
  localparam int RST_CYC  = 4;
  localparam int N_RAND   = 300;  // Random ADC and DAC cycles
  localparam int N_LOOP   = 100;  // Random cycles with loopback on
  localparam int N_DIR    = 10;   // Directed pairs near full scale
  localparam int N_ACC    = 40;   // Bus accesses, at most 3 cycles each
  localparam int PDM_WAIT = 300;  // One full window plus slack
  localparam int LIMIT    = RST_CYC + N_RAND + N_LOOP + 2 * N_DIR + 20 + 3 * N_ACC
                            + 2 * PDM_WAIT + 200;

  logic             adc_clk;
  logic             rst_i;
  adc_raw_pair_t    adc_raw_i;
  smp_pair_t        gen_dat_i;
  smp_pair_t        fb_dat_i;
  sys_req_t         sys_req_i;
  smp_pair_t        adc_dat_o;
  dac_code_pair_t   dac_dat_o;
  logic [N_PDM-1:0] pdm_o;
  sys_rsp_t         sys_rsp_o;

  // Reference model state
  logic                        m_loop;
  logic [N_PDM-1:0][PDM_W-1:0] m_pdm;
  adc_raw_pair_t               m_raw;     // Model of the input register
  dac_code_pair_t              m_code;    // Model of the output register
  smp_pair_t                   exp_adc;
  smp_pair_t                   exp_loop;
  sys_data_t                   exp_rd;
  sys_data_t                   exp_rd_q;
  logic                        exp_err;
  logic                        exp_err_q;
  logic                        pdm_wr;
  logic                        req_q;
  logic                        ren_q;
  logic                        rst_q;
  int                          stable_cnt;  // Cycles since the last PDM write
  logic [N_PDM-1:0][255:0]     hist;        // Last 256 PDM bits per output
  int                          ones [N_PDM];
  int                          cyc;
  int                          err_bus;
  int                          err_adc;
  int                          err_dac;
  int                          err_pdm;
  int                          err_rst;

  ////////////////////////////////////////////////////////////
  // Conversion rules
  ////////////////////////////////////////////////////////////

  // Top 14 bits, sign kept, rest inverted
  function automatic smp_t adc_decode(adc_raw_t raw);
    return smp_t'({raw[15], ~raw[14:2]});
  endfunction

  function automatic smp_t sat_sum(smp_t x, smp_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return smp_t'(s);
  endfunction

  function automatic dac_code_t offset_code(smp_t v);
    return {v[13], ~v[12:0]};
  endfunction

  function automatic smp_pair_t sat_pair(smp_pair_t g, smp_pair_t f);
    smp_pair_t r;
    r.a = sat_sum(g.a, f.a);
    r.b = sat_sum(g.b, f.b);
    return r;
  endfunction

  function automatic smp_pair_t rand_pair();
    smp_pair_t r;
    r.a = smp_t'($urandom());
    r.b = smp_t'($urandom());
    return r;
  endfunction

  afe_top #(
    .N_PDM (N_PDM)
  ) afe_top_inst (
    .adc_clk   (adc_clk  ),
    .rst_i     (rst_i    ),
    .adc_raw_i (adc_raw_i),
    .dac_dat_o (dac_dat_o),
    .pdm_o     (pdm_o    ),
    .gen_dat_i (gen_dat_i),
    .fb_dat_i  (fb_dat_i ),
    .adc_dat_o (adc_dat_o),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 50 MHz
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    exp_rd  = '0;
    exp_err = 1'b1;   // Unmapped until a match
    pdm_wr  = 1'b0;
    if (sys_req_i.addr == REG_ID)
    begin
      exp_rd  = AFE_ID;
      exp_err = 1'b0;
    end
    if (sys_req_i.addr == REG_CTRL)
    begin
      exp_rd  = {31'b0, m_loop};
      exp_err = 1'b0;
    end
    for (int i = 0; i < N_PDM; i++)
    begin
      if (sys_req_i.addr == REG_PDM0 + sys_addr_t'(4 * i))
      begin
        exp_rd[7:0] = m_pdm[i];
        exp_err     = 1'b0;
        pdm_wr      = sys_req_i.wen;
      end
    end
    exp_adc.a = adc_decode(m_raw.a);
    exp_adc.b = adc_decode(m_raw.b);
    exp_loop  = sat_pair(gen_dat_i, fb_dat_i);  // Same cycle in loopback
    for (int i = 0; i < N_PDM; i++)
      ones[i] = $countones(hist[i]);
  end

  always @(posedge adc_clk)
  begin
    rst_q     <= rst_i;
    req_q     <= sys_req_i.wen | sys_req_i.ren;
    ren_q     <= sys_req_i.ren;
    exp_rd_q  <= exp_rd;
    exp_err_q <= exp_err;
    for (int i = 0; i < N_PDM; i++)
      hist[i] <= {hist[i][254:0], pdm_o[i]};
    if (rst_i)
    begin
      m_loop     <= 1'b0;
      m_pdm      <= '0;
      m_raw      <= '0;
      m_code     <= '{b: offset_code(smp_t'(0)), a: offset_code(smp_t'(0))};
      stable_cnt <= 0;
    end
    else
    begin
      m_raw  <= adc_raw_i;
      m_code <= '{b: offset_code(sat_sum(gen_dat_i.b, fb_dat_i.b)),
                  a: offset_code(sat_sum(gen_dat_i.a, fb_dat_i.a))};
      if (sys_req_i.wen && sys_req_i.addr == REG_CTRL)
        m_loop <= sys_req_i.wdata[0];
      for (int i = 0; i < N_PDM; i++)
      begin
        if (sys_req_i.wen && sys_req_i.addr == REG_PDM0 + sys_addr_t'(4 * i))
          m_pdm[i] <= sys_req_i.wdata[7:0];
      end
      stable_cnt <= pdm_wr ? 0 : stable_cnt + 1;  // New duty restarts the window
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  bus_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.ack == req_q)
    else
    begin
      err_bus++;
      $display("ERR bus_ack expected %0b actual %0b",
               $sampled(req_q), $sampled(sys_rsp_o.ack));
    end

  bus_err: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.err == (req_q & exp_err_q))
    else
    begin
      err_bus++;
      $display("ERR bus_err expected %0b actual %0b",
               $sampled(req_q) & $sampled(exp_err_q), $sampled(sys_rsp_o.err));
    end

  bus_rdata: assert property (@(posedge adc_clk) disable iff (rst_i)
    ren_q |-> sys_rsp_o.rdata == exp_rd_q)
    else
    begin
      err_bus++;
      $display("ERR bus_rdata expected %h actual %h",
               $sampled(exp_rd_q), $sampled(sys_rsp_o.rdata));
    end

  adc_conv: assert property (@(posedge adc_clk) disable iff (rst_i)
    !m_loop |-> adc_dat_o == exp_adc)
    else
    begin
      err_adc++;
      $display("ERR adc_conv expected %h actual %h",
               $sampled(exp_adc), $sampled(adc_dat_o));
    end

  adc_loop: assert property (@(posedge adc_clk) disable iff (rst_i)
    m_loop |-> adc_dat_o == exp_loop)
    else
    begin
      err_adc++;
      $display("ERR adc_loop expected %h actual %h",
               $sampled(exp_loop), $sampled(adc_dat_o));
    end

  dac_out: assert property (@(posedge adc_clk) disable iff (rst_i)
    dac_dat_o == m_code)
    else
    begin
      err_dac++;
      $display("ERR dac_out expected %h actual %h",
               $sampled(m_code), $sampled(dac_dat_o));
    end

  // During reset and the cycle after it
  rst_state: assert property (@(posedge adc_clk)
    rst_q |-> !sys_rsp_o.ack && !sys_rsp_o.err && pdm_o == '0
              && dac_dat_o == {offset_code(smp_t'(0)), offset_code(smp_t'(0))})
    else
    begin
      err_rst++;
      $display("ERR rst_state expected ack/err/pdm/dac 0/0/0/%h actual %0b/%0b/%h/%h",
               {offset_code(smp_t'(0)), offset_code(smp_t'(0))},
               $sampled(sys_rsp_o.ack), $sampled(sys_rsp_o.err),
               $sampled(pdm_o), $sampled(dac_dat_o));
    end

  for (genvar i = 0; i < N_PDM; i++)
  begin : g_pdm
    pdm_density: assert property (@(posedge adc_clk) disable iff (rst_i)
      stable_cnt >= 256 |-> ones[i] == int'(m_pdm[i]))
      else
      begin
        err_pdm++;
        $display("ERR pdm_density[%0d] expected %0d actual %0d",
                 i, $sampled(m_pdm[i]), $sampled(ones[i]));
      end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic bus_start(input sys_addr_t addr, input sys_data_t data, input logic wr);
    @(posedge adc_clk);
    sys_req_i <= '{addr: addr, wdata: data, wen: wr, ren: !wr};
  endtask

  task automatic bus_stop();
    @(posedge adc_clk);
    sys_req_i.wen <= 1'b0;
    sys_req_i.ren <= 1'b0;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do
    begin
      @(negedge adc_clk);  // Stable sampling point
      n++;
    end
    while (!sys_rsp_o.ack && n < 4);
    if (!sys_rsp_o.ack)
    begin
      err_bus++;
      $display("Bus: no ack seen after the request");
    end
  endtask

  task automatic bus_access(input sys_addr_t addr, input sys_data_t data, input logic wr);
    bus_start(addr, data, wr);
    bus_stop();
    wait_ack();
  endtask

  // Duty bytes back to back, then read them back the same way
  task automatic pdm_burst(input logic [PDM_W-1:0] d0, input logic [PDM_W-1:0] d1);
    bus_start(REG_PDM0, sys_data_t'(d0), 1'b1);
    bus_start(REG_PDM0 + 20'h4, sys_data_t'(d1), 1'b1);
    bus_start(REG_PDM0 + 20'h8, sys_data_t'($urandom_range(0, 255)), 1'b1);
    bus_start(REG_PDM0 + 20'hC, sys_data_t'($urandom_range(0, 255)), 1'b1);
    for (int i = 0; i < N_PDM; i++)
      bus_start(REG_PDM0 + sys_addr_t'(4 * i), '0, 1'b0);
    bus_stop();
    wait_ack();
  endtask

  task automatic drive_random(input int n);
    repeat (n)
    begin
      @(posedge adc_clk);
      adc_raw_i <= adc_raw_pair_t'($urandom());  // Low two bits random too
      gen_dat_i <= rand_pair();
      fb_dat_i  <= rand_pair();
    end
  endtask

  task automatic drive_edges();
    int x [N_DIR];
    int y [N_DIR];
    x = '{8191, 8191, -8192, -8192, 8000, 8000, -8000, -8000, 4095, 0};
    y = '{1, 8191, -1, -8192, 191, 192, -192, -193, 4096, 0};
    for (int i = 0; i < N_DIR; i++)
    begin
      @(posedge adc_clk);
      gen_dat_i <= '{b: smp_t'(y[i]), a: smp_t'(x[i])};
      fb_dat_i  <= '{b: smp_t'(x[i]), a: smp_t'(y[i])};
    end
  endtask

  always @(posedge adc_clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial
  begin
    int seed;
    int total;
    seed    = $urandom(SEED);
    cyc     = 0;
    err_bus = 0;
    err_adc = 0;
    err_dac = 0;
    err_pdm = 0;
    err_rst = 0;
    rst_i     = 1'b1;
    adc_raw_i = '0;
    gen_dat_i = '0;
    fb_dat_i  = '0;
    sys_req_i = '0;
    repeat (RST_CYC) @(posedge adc_clk);
    rst_i <= 1'b0;
    @(posedge adc_clk);

    // Register map, err on unmapped, REG_ID read only
    bus_access(REG_ID, '0, 1'b0);
    bus_access(REG_ID, 32'h1234_5678, 1'b1);
    bus_access(REG_ID, '0, 1'b0);
    bus_access(REG_CTRL, '0, 1'b0);
    bus_access(20'h00100, 32'hDEAD_BEEF, 1'b1);
    bus_access(20'h00100, '0, 1'b0);
    bus_access(REG_PDM0 + sys_addr_t'(4 * N_PDM), '0, 1'b0);  // Just past the bank
    pdm_burst(8'h5A, 8'hC3);

    // ADC and DAC path
    drive_random(N_RAND);
    drive_edges();

    // Loopback on, then back to the converter
    bus_access(REG_CTRL, 32'h1, 1'b1);
    bus_access(REG_CTRL, '0, 1'b0);
    drive_random(N_LOOP);
    drive_edges();
    bus_access(REG_CTRL, '0, 1'b1);
    drive_random(20);

    // PDM density, full windows after each set
    pdm_burst(8'd0, 8'd255);
    repeat (PDM_WAIT) @(posedge adc_clk);
    pdm_burst(8'd255, 8'd0);
    repeat (PDM_WAIT) @(posedge adc_clk);

    @(negedge adc_clk);
    total = err_bus + err_adc + err_dac + err_pdm + err_rst;
    $display("Errors: bus %0d, adc %0d, dac %0d, pdm %0d, reset %0d, total %0d",
             err_bus, err_adc, err_dac, err_pdm, err_rst, total);
    if (total == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
